/* uv_pkg.sv */
// Shared types for the chroma intra-mode decision block
// Geometry, mode and state encodings, packed payload structs

package uv_pkg;

    // ------------------------------------------------------------
    // Block geometry
    // ------------------------------------------------------------
    localparam int uv_pix_num   = 32;
    localparam int uv_plane_num = 16;
    localparam int uv_planes    = 2;
    localparam int uv_side      = 4;

    // Evaluation order follows the encoding
    typedef enum logic [1:0] {
        mode_dc = 2'd0,
        mode_tm = 2'd1,
        mode_v  = 2'd2,
        mode_h  = 2'd3
    } uv_mode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_pred,
        st_recon,
        st_score,
        st_comp,
        st_done
    } uv_state_e;

    // U in pixels 0..15, V in 16..31, raster order
    typedef struct packed {
        logic [uv_pix_num-1:0][7:0] pix;
    } uv_block_t;

    typedef struct packed {
        logic [uv_pix_num-1:0][8:0] lvl;
    } uv_levels_t;

    typedef struct packed {
        logic [uv_side-1:0][7:0] top_u;
        logic [uv_side-1:0][7:0] top_v;
        logic [uv_side-1:0][7:0] left_u;
        logic [uv_side-1:0][7:0] left_v;
        logic [7:0]              tl_u;
        logic [7:0]              tl_v;
    } uv_edges_t;

    typedef struct packed {
        logic [15:0] lambda;
        logic [2:0]  qshift;
        logic [15:0] cost_dc;
        logic [15:0] cost_tm;
        logic [15:0] cost_v;
        logic [15:0] cost_h;
    } uv_cfg_t;

    typedef struct packed {
        uv_mode_e    mode;
        uv_block_t   recon;
        uv_levels_t  levels;
        logic [1:0]  nz;
        logic [47:0] score;
    } uv_result_t;

    // Saturate to the 8-bit pixel range
    function automatic logic [7:0] uv_clip(input int v);
        if (v < 0) begin
            return 8'd0;
        end else if (v > 255) begin
            return 8'd255;
        end
        return 8'(v);
    endfunction

endpackage

/* uv_cost_regs.sv */
// Configuration registers for the chroma mode decision
// Lambda, quantizer shift and the four fixed mode costs

`timescale 1ns/1ps

module uv_cost_regs
    import uv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_wr,
    input  logic [2:0]  cfg_addr,
    input  logic [15:0] cfg_data,
    output uv_cfg_t     cfg
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.lambda  <= 16'd1;
            cfg.qshift  <= 3'd2;
            cfg.cost_dc <= 16'd302;
            cfg.cost_tm <= 16'd984;
            cfg.cost_v  <= 16'd439;
            cfg.cost_h  <= 16'd642;
        end else if (cfg_wr) begin
            case (cfg_addr)
                3'd0: cfg.lambda  <= cfg_data;
                3'd1: cfg.qshift  <= cfg_data[2:0];
                3'd2: cfg.cost_dc <= cfg_data;
                3'd3: cfg.cost_tm <= cfg_data;
                3'd4: cfg.cost_v  <= cfg_data;
                3'd5: cfg.cost_h  <= cfg_data;
                // Addresses 6 and 7 are unmapped
                default: ;
            endcase
        end
    end

endmodule

/* uv_pred.sv */
// Chroma intra predictor
// Builds the DC, TM, V or H pattern for U and V and registers it

`timescale 1ns/1ps

module uv_pred
    import uv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pred_go,
    input  uv_mode_e   mode_sel,
    input  uv_edges_t  edges,
    input  logic [9:0] mb_x,
    input  logic [9:0] mb_y,
    output uv_block_t  pred,
    output logic       pred_valid
);

    logic [uv_planes-1:0][uv_side-1:0][7:0] top_p;
    logic [uv_planes-1:0][uv_side-1:0][7:0] left_p;
    logic [uv_planes-1:0][7:0]              tl_p;
    logic [uv_planes-1:0][7:0]              dc_p;
    logic                                   has_top;
    logic                                   has_left;
    uv_block_t                              pred_next;

    // Average of whichever edges exist at this position
    function automatic logic [7:0] dc_value(
        input logic [uv_side-1:0][7:0] top,
        input logic [uv_side-1:0][7:0] left,
        input logic                    use_top,
        input logic                    use_left
    );
        logic [10:0] sum_top;
        logic [10:0] sum_left;
        sum_top  = '0;
        sum_left = '0;
        for (int k = 0; k < uv_side; k++) begin
            sum_top  = sum_top + 11'(top[k]);
            sum_left = sum_left + 11'(left[k]);
        end
        if (use_top && use_left) begin
            return 8'((sum_top + sum_left + 11'd4) >> 3);
        end else if (use_top) begin
            return 8'((sum_top + 11'd2) >> 2);
        end else if (use_left) begin
            return 8'((sum_left + 11'd2) >> 2);
        end
        return 8'd128;
    endfunction

    assign has_top  = (mb_y != 10'd0);
    assign has_left = (mb_x != 10'd0);

    // Index 0 is U, index 1 is V
    assign top_p  = {edges.top_v, edges.top_u};
    assign left_p = {edges.left_v, edges.left_u};
    assign tl_p   = {edges.tl_v, edges.tl_u};

    assign dc_p[0] = dc_value(edges.top_u, edges.left_u, has_top, has_left);
    assign dc_p[1] = dc_value(edges.top_v, edges.left_v, has_top, has_left);

    always_comb begin
        int idx;
        pred_next = '0;
        for (int p = 0; p < uv_planes; p++) begin
            for (int r = 0; r < uv_side; r++) begin
                for (int c = 0; c < uv_side; c++) begin
                    idx = p * uv_plane_num + r * uv_side + c;
                    case (mode_sel)
                        mode_dc: pred_next.pix[idx] = dc_p[p];
                        mode_tm: pred_next.pix[idx] = uv_clip(int'(left_p[p][r])
                                     + int'(top_p[p][c]) - int'(tl_p[p]));
                        mode_v:  pred_next.pix[idx] = top_p[p][c];
                        default: pred_next.pix[idx] = left_p[p][r];
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= pred_go;
        end
    end

    always_ff @(posedge clk) begin
        if (pred_go) begin
            pred <= pred_next;
        end
    end

endmodule

/* uv_quant_recon.sv */
// Quantizer and reconstructor for one chroma prediction
// Shift quantization of the residual, clipped reconstruction, per-plane nonzero flags

`timescale 1ns/1ps

module uv_quant_recon
    import uv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pred_valid,
    input  uv_block_t  src,
    input  uv_block_t  pred,
    input  logic [2:0] qshift,
    output uv_levels_t levels,
    output uv_block_t  recon,
    output logic [1:0] nz,
    output logic       rec_valid
);

    uv_levels_t levels_next;
    uv_block_t  recon_next;
    logic [1:0] nz_next;

    // ------------------------------------------------------------
    // All 32 pixels in parallel
    // ------------------------------------------------------------
    always_comb begin
        int resid;
        int mag;
        int lvl;
        int rec;
        levels_next = '0;
        recon_next  = '0;
        nz_next     = '0;
        for (int i = 0; i < uv_pix_num; i++) begin
            resid = int'(src.pix[i]) - int'(pred.pix[i]);
            mag   = (resid < 0) ? -resid : resid;
            // Magnitude is truncated, so small residuals fall to zero
            mag   = mag >> qshift;
            lvl   = (resid < 0) ? -mag : mag;
            rec   = int'(pred.pix[i]) + (lvl <<< qshift);

            levels_next.lvl[i] = 9'(lvl);
            recon_next.pix[i]  = uv_clip(rec);
            if (lvl != 0) begin
                nz_next[i / uv_plane_num] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= pred_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pred_valid) begin
            levels <= levels_next;
            recon  <= recon_next;
            nz     <= nz_next;
        end
    end

endmodule

/* uv_score.sv */
// Rate-distortion scorer for one chroma candidate
// Walks the 32 pixels serially, then applies the cost formula

`timescale 1ns/1ps

module uv_score
    import uv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rec_valid,
    input  uv_block_t   src,
    input  uv_block_t   recon,
    input  uv_levels_t  levels,
    input  logic [15:0] lambda,
    input  logic [15:0] fixed_cost,
    output logic [47:0] score,
    output logic        score_valid
);

    logic [4:0]  pix_cnt;
    logic        busy;
    logic        active;
    logic [20:0] sse_acc;
    logic [12:0] lvl_acc;
    logic [7:0]  diff_abs;
    logic [15:0] err_sq;
    logic [8:0]  lvl_cur;
    logic [7:0]  lvl_abs;
    logic [20:0] sse_sum;
    logic [12:0] lvl_sum;
    logic [17:0] rate;
    logic [47:0] score_next;

    // Pixel 0 is taken in the rec_valid cycle itself
    assign active = rec_valid | busy;

    assign diff_abs = (src.pix[pix_cnt] >= recon.pix[pix_cnt]) ?
                      src.pix[pix_cnt] - recon.pix[pix_cnt] :
                      recon.pix[pix_cnt] - src.pix[pix_cnt];
    assign err_sq   = diff_abs * diff_abs;

    assign lvl_cur = levels.lvl[pix_cnt];
    assign lvl_abs = lvl_cur[8] ? 8'(~lvl_cur + 9'd1) : lvl_cur[7:0];

    assign sse_sum = sse_acc + 21'(err_sq);
    assign lvl_sum = lvl_acc + 13'(lvl_abs);

    // Rate is level sum times 16 plus the mode cost
    assign rate       = 18'({lvl_sum, 4'b0000}) + 18'(fixed_cost);
    assign score_next = 48'(rate) * 48'(lambda) + 48'({sse_sum, 8'h00});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt     <= '0;
            busy        <= 1'b0;
            sse_acc     <= '0;
            lvl_acc     <= '0;
            score_valid <= 1'b0;
        end else begin
            score_valid <= 1'b0;
            if (active) begin
                pix_cnt <= pix_cnt + 5'd1;
                if (pix_cnt == 5'd31) begin
                    busy        <= 1'b0;
                    sse_acc     <= '0;
                    lvl_acc     <= '0;
                    score_valid <= 1'b1;
                end else begin
                    busy    <= 1'b1;
                    sse_acc <= sse_sum;
                    lvl_acc <= lvl_sum;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && pix_cnt == 5'd31) begin
            score <= score_next;
        end
    end

endmodule

/* uv_mode_ctrl.sv */
// Mode decision controller
// Steps through DC, TM, V and H and keeps the lowest-scoring result

`timescale 1ns/1ps

module uv_mode_ctrl
    import uv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  uv_cfg_t     cfg,
    input  logic        pred_valid,
    input  logic        rec_valid,
    input  logic        score_valid,
    input  logic [47:0] score,
    input  uv_levels_t  levels,
    input  uv_block_t   recon,
    input  logic [1:0]  nz,
    output logic        pred_go,
    output uv_mode_e    mode_sel,
    output logic [15:0] fixed_cost,
    output uv_result_t  result,
    output logic        done
);

    uv_state_e  state;
    uv_mode_e   cur_mode;
    logic       first;
    logic [1:0] next_mode;
    logic       last_mode;
    logic       better;

    function automatic logic [15:0] cost_of(input uv_cfg_t c, input uv_mode_e m);
        case (m)
            mode_dc: return c.cost_dc;
            mode_tm: return c.cost_tm;
            mode_v:  return c.cost_v;
            default: return c.cost_h;
        endcase
    endfunction

    assign next_mode = mode_sel + 2'd1;
    assign last_mode = (cur_mode == mode_h);
    // Strict compare, so a tie keeps the earlier mode
    assign better    = first || (score < result.score);

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            pred_go    <= 1'b0;
            mode_sel   <= mode_dc;
            cur_mode   <= mode_dc;
            fixed_cost <= '0;
            first      <= 1'b0;
            done       <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        pred_go    <= 1'b1;
                        mode_sel   <= mode_dc;
                        cur_mode   <= mode_dc;
                        fixed_cost <= cfg.cost_dc;
                        first      <= 1'b1;
                        state      <= st_pred;
                    end
                end
                st_pred: begin
                    pred_go <= 1'b0;
                    if (pred_valid) begin
                        state <= st_recon;
                    end
                end
                st_recon: begin
                    if (rec_valid) begin
                        state <= st_score;
                    end
                end
                st_score: begin
                    if (score_valid) begin
                        state <= st_comp;
                        // Next prediction overlaps the compare cycle
                        if (!last_mode) begin
                            pred_go    <= 1'b1;
                            mode_sel   <= uv_mode_e'(next_mode);
                            fixed_cost <= cost_of(cfg, uv_mode_e'(next_mode));
                        end
                    end
                end
                st_comp: begin
                    pred_go <= 1'b0;
                    first   <= 1'b0;
                    if (last_mode) begin
                        done  <= 1'b1;
                        state <= st_done;
                    end else begin
                        cur_mode <= mode_sel;
                        state    <= st_pred;
                    end
                end
                st_done: begin
                    done  <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Candidate outputs stay stable through st_comp
    always_ff @(posedge clk) begin
        if (state == st_comp && better) begin
            result.mode   <= cur_mode;
            result.recon  <= recon;
            result.levels <= levels;
            result.nz     <= nz;
            result.score  <= score;
        end
    end

endmodule

/* uv_pick_best.sv */
// Chroma intra-mode decision top level
// Predictor, quantizer, scorer, controller and configuration registers

`timescale 1ns/1ps

module uv_pick_best
    import uv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  uv_block_t   src,
    input  uv_edges_t   edges,
    input  logic [9:0]  mb_x,
    input  logic [9:0]  mb_y,
    input  logic        cfg_wr,
    input  logic [2:0]  cfg_addr,
    input  logic [15:0] cfg_data,
    output uv_result_t  result,
    output logic        done
);

    uv_cfg_t     cfg;
    logic        pred_go;
    uv_mode_e    mode_sel;
    uv_block_t   pred;
    logic        pred_valid;
    uv_levels_t  levels;
    uv_block_t   recon;
    logic [1:0]  nz;
    logic        rec_valid;
    logic [47:0] score;
    logic        score_valid;
    logic [15:0] fixed_cost;

    uv_cost_regs u_cost_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg      (cfg)
    );

    uv_pred u_pred (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_go    (pred_go),
        .mode_sel   (mode_sel),
        .edges      (edges),
        .mb_x       (mb_x),
        .mb_y       (mb_y),
        .pred       (pred),
        .pred_valid (pred_valid)
    );

    uv_quant_recon u_quant_recon (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_valid (pred_valid),
        .src        (src),
        .pred       (pred),
        .qshift     (cfg.qshift),
        .levels     (levels),
        .recon      (recon),
        .nz         (nz),
        .rec_valid  (rec_valid)
    );

    uv_score u_score (
        .clk         (clk),
        .rst_n       (rst_n),
        .rec_valid   (rec_valid),
        .src         (src),
        .recon       (recon),
        .levels      (levels),
        .lambda      (cfg.lambda),
        .fixed_cost  (fixed_cost),
        .score       (score),
        .score_valid (score_valid)
    );

    uv_mode_ctrl u_mode_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .pred_valid  (pred_valid),
        .rec_valid   (rec_valid),
        .score_valid (score_valid),
        .score       (score),
        .levels      (levels),
        .recon       (recon),
        .nz          (nz),
        .pred_go     (pred_go),
        .mode_sel    (mode_sel),
        .fixed_cost  (fixed_cost),
        .result      (result),
        .done        (done)
    );

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 40 ns clock, reset held low for the first two cycles

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tb_uv_pick_best.sv */
// Testbench for the chroma intra-mode decision block
// Reference model of the mode rules, random and directed blocks, assertion checks

`timescale 1ns/1ps

module tb_uv_pick_best
    import uv_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        start;
    uv_block_t   src;
    uv_edges_t   edges;
    logic [9:0]  mb_x;
    logic [9:0]  mb_y;
    logic        cfg_wr;
    logic [2:0]  cfg_addr;
    logic [15:0] cfg_data;
    uv_result_t  result;
    logic        done;

    logic [31:0] lfsr_state;
    logic        armed;
    int          m_lambda;
    int          m_qshift;
    int          m_cost[4];

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uv_pick_best u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .src      (src),
        .edges    (edges),
        .mb_x     (mb_x),
        .mb_y     (mb_y),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .result   (result),
        .done     (done)
    );

    // done is a single-cycle pulse and only answers a start
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else stop_failed(error_text("done held high for more than one cycle"));
    assert property (@(posedge clk) disable iff (!rst_n) done |-> armed)
        else stop_failed(error_text("done pulsed without a start"));

    // ------------------------------------------------------------
    // Failure reporting and random source
    // ------------------------------------------------------------
    function automatic string error_text(input string msg);
        return $sformatf("Error at %0t: %s", $time, msg);
    endfunction

    task automatic stop_failed(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Stopping on first failure");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[k] = lfsr_state[0];
        end
    endtask

    task automatic random_block(output uv_block_t b);
        logic [7:0] px;
        for (int i = 0; i < uv_pix_num; i++) begin
            next_byte(px);
            b.pix[i] = px;
        end
    endtask

    task automatic random_edges(output uv_edges_t e);
        logic [7:0] px;
        for (int k = 0; k < 18; k++) begin
            next_byte(px);
            e[k*8 +: 8] = px;
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic int clip8(input int v);
        return (v < 0) ? 0 : ((v > 255) ? 255 : v);
    endfunction

    function automatic uv_block_t predict(input uv_mode_e m, input uv_edges_t e,
                                          input logic [9:0] x, input logic [9:0] y);
        uv_block_t       p;
        logic [3:0][7:0] top;
        logic [3:0][7:0] left;
        int              tl;
        int              st;
        int              sl;
        int              dc;
        int              v;
        for (int pl = 0; pl < 2; pl++) begin
            top  = (pl == 0) ? e.top_u : e.top_v;
            left = (pl == 0) ? e.left_u : e.left_v;
            tl   = (pl == 0) ? int'(e.tl_u) : int'(e.tl_v);
            st   = 0;
            sl   = 0;
            for (int k = 0; k < 4; k++) begin
                st = st + int'(top[k]);
                sl = sl + int'(left[k]);
            end
            if (x != 0 && y != 0) begin
                dc = (st + sl + 4) >> 3;
            end else if (y != 0) begin
                dc = (st + 2) >> 2;
            end else if (x != 0) begin
                dc = (sl + 2) >> 2;
            end else begin
                dc = 128;
            end
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    case (m)
                        mode_dc: v = dc;
                        mode_tm: v = clip8(int'(left[r]) + int'(top[c]) - tl);
                        mode_v:  v = int'(top[c]);
                        default: v = int'(left[r]);
                    endcase
                    p.pix[pl*16 + r*4 + c] = v[7:0];
                end
            end
        end
        return p;
    endfunction

    function automatic uv_result_t eval_mode(input uv_mode_e m);
        uv_result_t res;
        uv_block_t  p;
        int         r;
        int         mag;
        int         lvl;
        int         rec;
        int         d;
        longint     sse;
        longint     lsum;
        longint     total;
        p    = predict(m, edges, mb_x, mb_y);
        res  = '0;
        sse  = 0;
        lsum = 0;
        res.mode = m;
        for (int i = 0; i < uv_pix_num; i++) begin
            r   = int'(src.pix[i]) - int'(p.pix[i]);
            mag = ((r < 0) ? -r : r) >> m_qshift;
            lvl = (r < 0) ? -mag : mag;
            rec = clip8(int'(p.pix[i]) + lvl * (1 << m_qshift));
            d   = int'(src.pix[i]) - rec;
            res.levels.lvl[i] = lvl[8:0];
            res.recon.pix[i]  = rec[7:0];
            if (lvl != 0) begin
                res.nz[i / 16] = 1'b1;
            end
            sse  = sse + longint'(d * d);
            lsum = lsum + longint'(mag);
        end
        total = (lsum * 16 + longint'(m_cost[int'(m)])) * longint'(m_lambda) + 256 * sse;
        res.score = total[47:0];
        return res;
    endfunction

    // Ties keep the earlier mode
    function automatic uv_result_t expected_best();
        uv_result_t best;
        uv_result_t cand;
        best = eval_mode(mode_dc);
        for (int k = 1; k < 4; k++) begin
            cand = eval_mode(uv_mode_e'(k));
            if (cand.score < best.score) begin
                best = cand;
            end
        end
        return best;
    endfunction

    // ------------------------------------------------------------
    // Drivers and checks
    // ------------------------------------------------------------
    task automatic write_cfg(input logic [2:0] addr, input logic [15:0] data);
        @(posedge clk);
        cfg_wr   <= 1'b1;
        cfg_addr <= addr;
        cfg_data <= data;
        @(posedge clk);
        cfg_wr   <= 1'b0;
        case (addr)
            3'd0:    m_lambda = int'(data);
            3'd1:    m_qshift = int'(data[2:0]);
            default: m_cost[int'(addr) - 2] = int'(data);
        endcase
    endtask

    task automatic load_inputs(input uv_block_t b, input uv_edges_t e,
                               input logic [9:0] x, input logic [9:0] y);
        @(posedge clk);
        src   <= b;
        edges <= e;
        mb_x  <= x;
        mb_y  <= y;
    endtask

    // Pulses start, optionally pulses it again at cycle restart_at, waits for done
    task automatic run_block(input int restart_at, output int cycles);
        int   n;
        logic seen;
        n     = 0;
        seen  = 1'b0;
        armed = 1'b1;
        @(posedge clk);
        start <= 1'b1;
        while (!seen && n < 300) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end else begin
                n++;
                @(posedge clk);
                start <= (n == restart_at);
            end
        end
        cycles = n;
        assert (seen) else stop_failed("Timed out after 300 cycles waiting for done");
        @(negedge clk);
        armed = 1'b0;
    endtask

    task automatic check_result(input uv_result_t exp, input string tag);
        assert (result.mode == exp.mode)
            else stop_failed(error_text($sformatf("%s: mode %0d, expected %0d",
                                                  tag, result.mode, exp.mode)));
        assert (result.score == exp.score)
            else stop_failed(error_text($sformatf("%s: score %0d, expected %0d",
                                                  tag, result.score, exp.score)));
        assert (result.nz == exp.nz)
            else stop_failed(error_text($sformatf("%s: nz %b, expected %b",
                                                  tag, result.nz, exp.nz)));
        for (int i = 0; i < uv_pix_num; i++) begin
            assert (result.recon.pix[i] == exp.recon.pix[i])
                else stop_failed(error_text($sformatf("%s: recon[%0d] %0d, expected %0d",
                                 tag, i, result.recon.pix[i], exp.recon.pix[i])));
            assert (result.levels.lvl[i] == exp.levels.lvl[i])
                else stop_failed(error_text($sformatf("%s: level[%0d] %h, expected %h",
                                 tag, i, result.levels.lvl[i], exp.levels.lvl[i])));
        end
    endtask

    task automatic decide_and_check(input int restart_at, input string tag);
        int cycles;
        run_block(restart_at, cycles);
        assert (cycles == 142)
            else stop_failed(error_text($sformatf("%s: done after %0d cycles, expected 142",
                                                  tag, cycles)));
        check_result(expected_best(), tag);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        uv_block_t  blk;
        uv_block_t  dc_pred;
        uv_edges_t  edg;
        logic [7:0] val;
        logic [1:0] nz_exp;
        logic [9:0] xs[3];
        logic [9:0] ys[3];
        int         waited;

        start      <= 1'b0;
        src        <= '0;
        edges      <= '0;
        mb_x       <= '0;
        mb_y       <= '0;
        cfg_wr     <= 1'b0;
        cfg_addr   <= '0;
        cfg_data   <= '0;
        lfsr_state = 32'hff34_e3e6;
        armed      = 1'b0;
        m_lambda   = 1;
        m_qshift   = 2;
        m_cost     = '{302, 984, 439, 642};

        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        assert (rst_n === 1'b1) else stop_failed("Reset was not released within 20 cycles");

        // Idle after reset
        repeat (20) begin
            @(negedge clk);
            assert (!done) else stop_failed(error_text("done high while idle after reset"));
        end

        // Random blocks at interior positions
        for (int k = 0; k < 4; k++) begin
            random_block(blk);
            random_edges(edg);
            load_inputs(blk, edg, 10'(1 + k * 3), 10'(2 + k * 5));
            decide_and_check(0, $sformatf("random %0d", k));
        end

        // Source copied from a later mode's prediction so that mode replaces DC
        for (int k = 1; k < 4; k++) begin
            random_edges(edg);
            blk = predict(uv_mode_e'(k), edg, 10'd3, 10'd7);
            load_inputs(blk, edg, 10'd3, 10'd7);
            decide_and_check(0, $sformatf("exact mode %0d", k));
            assert (result.mode == uv_mode_e'(k))
                else stop_failed(error_text($sformatf("exact mode %0d was not picked", k)));
        end

        // DC at frame edges with a flat source equal to the DC value
        xs = '{10'd0, 10'd0, 10'd5};
        ys = '{10'd0, 10'd5, 10'd0};
        for (int k = 0; k < 3; k++) begin
            random_edges(edg);
            blk = predict(mode_dc, edg, xs[k], ys[k]);
            load_inputs(blk, edg, xs[k], ys[k]);
            decide_and_check(0, $sformatf("dc edge (%0d,%0d)", xs[k], ys[k]));
            assert (result.mode == mode_dc && result.levels.lvl == '0)
                else stop_failed(error_text("flat source at frame edge did not pick DC"));
        end

        // Second start while busy
        random_block(blk);
        random_edges(edg);
        load_inputs(blk, edg, 10'd6, 10'd9);
        decide_and_check(50, "busy restart");

        // Equal edges and equal costs give a four-way tie
        next_byte(val);
        for (int k = 0; k < 18; k++) begin
            edg[k*8 +: 8] = val;
        end
        for (int a = 2; a < 6; a++) begin
            write_cfg(3'(a), 16'd500);
        end
        random_block(blk);
        load_inputs(blk, edg, 10'd2, 10'd3);
        decide_and_check(0, "tie");
        assert (result.mode == mode_dc)
            else stop_failed(error_text("tie did not keep DC"));

        // Lossless setting with the U plane flat at its DC value
        write_cfg(3'd0, 16'd0);
        write_cfg(3'd1, 16'd0);
        random_edges(edg);
        random_block(blk);
        dc_pred = predict(mode_dc, edg, 10'd4, 10'd4);
        nz_exp  = '0;
        for (int i = 0; i < uv_pix_num; i++) begin
            if (i < 16) begin
                blk.pix[i] = dc_pred.pix[i];
            end
            if (blk.pix[i] != dc_pred.pix[i]) begin
                nz_exp[i / 16] = 1'b1;
            end
        end
        load_inputs(blk, edg, 10'd4, 10'd4);
        decide_and_check(0, "lossless");
        assert (result.recon == src)
            else stop_failed(error_text("lossless recon differs from source"));
        assert (result.nz == nz_exp)
            else stop_failed(error_text($sformatf("lossless nz %b, expected %b",
                                                  result.nz, nz_exp)));

        $display("Simulation passed");
        $finish;
    end

endmodule

/* files.f */
uv_pkg.sv
uv_cost_regs.sv
uv_pred.sv
uv_quant_recon.sv
uv_score.sv
uv_mode_ctrl.sv
uv_pick_best.sv
tb_clock_gen.sv
tb_uv_pick_best.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_uv_pick_best
RTL_TOP   := uv_pick_best
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
